/* flist.f */
+incdir+include
hw/dram_bridge_pkg.sv
hw/host_csr_bank.sv
hw/dma_rr_arbiter.sv
hw/dram_window.sv
hw/read_return_router.sv
hw/zynq_dram_bridge.sv
bench/tb_clk_gen.sv
bench/tb_zynq_dram_bridge.sv

/* Makefile */
# Verilator build and run of the DRAM bridge testbench
VERILATOR ?= verilator
TOP       ?= tb_zynq_dram_bridge
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "PASS: all tests" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_zynq_dram_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_bridge_defs.svh"

module tb_zynq_dram_bridge;

   import dram_bridge_pkg::*;

   localparam int WATCHDOG_CYCLES = 2000;
   localparam int ISSUE_TIMEOUT   = 100;
   localparam int DRAIN_TIMEOUT   = 200;

   logic                                     clk;
   logic                                     arst_n;
   logic                                     csr_we;
   logic                                     csr_re;
   csr_idx_e                                 csr_addr;
   logic [`DB_CSR_W-1:0]                     csr_wdata;
   logic [`DB_CSR_W-1:0]                     csr_rdata_o;
   logic                                     csr_rvalid_o;
   logic [`DB_NUM_CH-1:0]                    ch_req_v;
   dma_op_e [`DB_NUM_CH-1:0]                 ch_req_op;
   logic [`DB_NUM_CH-1:0][`DB_ADDR_W-1:0]    ch_req_addr;
   logic [`DB_NUM_CH-1:0][`DB_DATA_W-1:0]    ch_req_wdata;
   logic [`DB_NUM_CH-1:0]                    ch_req_yumi_o;
   logic [`DB_NUM_CH-1:0]                    ch_rvalid_o;
   logic [`DB_NUM_CH-1:0][`DB_DATA_W-1:0]    ch_rdata_o;
   logic                                     mem_v_o;
   logic                                     mem_ready;
   dma_op_e                                  mem_op_o;
   logic [`DB_ADDR_W-1:0]                    mem_addr_o;
   logic [`DB_DATA_W-1:0]                    mem_wdata_o;
   logic                                     mem_rvalid;
   logic [`DB_DATA_W-1:0]                    mem_rdata;

   int                                       errors = 0;
   int                                       cyc = 0;
   logic [31:0]                              lfsr_state = 32'h9cc95782;
   logic [31:0]                              base_val = '0;
   logic                                     ready_rand = 1'b0;
   logic                                     ready_fixed = 1'b0;
   logic                                     resp_en = 1'b0;
   logic [63:0]                              exp_q0 [$];
   logic [63:0]                              exp_q1 [$];
   logic [63:0]                              pend_data [$];
   int                                       pend_due [$];

   tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(2)) clkgen
     (.clk_o(clk), .arst_n_o(arst_n));

   zynq_dram_bridge dut_i
     (.clk_i(clk), .arst_n_i(arst_n)
      ,.csr_we_i(csr_we), .csr_re_i(csr_re), .csr_addr_i(csr_addr)
      ,.csr_wdata_i(csr_wdata), .csr_rdata_o(csr_rdata_o), .csr_rvalid_o(csr_rvalid_o)
      ,.ch_req_v_i(ch_req_v), .ch_req_op_i(ch_req_op), .ch_req_addr_i(ch_req_addr)
      ,.ch_req_wdata_i(ch_req_wdata), .ch_req_yumi_o(ch_req_yumi_o)
      ,.ch_rvalid_o(ch_rvalid_o), .ch_rdata_o(ch_rdata_o)
      ,.mem_v_o(mem_v_o), .mem_ready_i(mem_ready), .mem_op_o(mem_op_o)
      ,.mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o)
      ,.mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
      );

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   // right-shift Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // processor window address to host DRAM address
   function automatic logic [31:0] xlate(input logic [31:0] a);
      xlate = (a ^ 32'h8000_0000) + base_val;
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
   endtask

   task automatic report_error(input string msg);
      $display("error: %s", msg);
      errors++;
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic csr_write(input csr_idx_e idx, input logic [31:0] data);
      csr_we    = 1'b1;
      csr_addr  = idx;
      csr_wdata = data;
      step();
      csr_we = 1'b0;
   endtask

   task automatic set_base(input logic [31:0] b);
      csr_write(e_csr_base, b);
      base_val = b;
   endtask

   // rvalid must be low in the strobe cycle and high in the next
   task automatic csr_read(input csr_idx_e idx, output logic [31:0] data);
      csr_re   = 1'b1;
      csr_addr = idx;
      @(negedge clk);
      if (csr_rvalid_o !== 1'b0)
         report_error("csr_rvalid_o high in the same cycle as csr_re_i");
      step();
      csr_re = 1'b0;
      @(negedge clk);
      if (csr_rvalid_o !== 1'b1)
         report_error("csr_rvalid_o did not rise one cycle after csr_re_i");
      data = csr_rdata_o;
      step();
   endtask

   task automatic expect_read(input int ch, input logic [31:0] xa);
      if (ch == 0)
         exp_q0.push_back({xa, xa});
      else
         exp_q1.push_back({xa, xa});
   endtask

   // hold one request until it is accepted and check the DRAM side
   task automatic issue(input int ch, input dma_op_e op, input logic [31:0] addr,
                        input logic [63:0] wdata);
      int          n;
      logic        done;
      logic [31:0] xa;
      xa   = xlate(addr);
      n    = 0;
      done = 1'b0;
      ch_req_v[ch]     = 1'b1;
      ch_req_op[ch]    = op;
      ch_req_addr[ch]  = addr;
      ch_req_wdata[ch] = wdata;
      while (!done && n < ISSUE_TIMEOUT)
      begin
         @(negedge clk);
         if (ch_req_yumi_o[ch])
         begin
            done = 1'b1;
            if (mem_addr_o !== xa)
               report_mismatch("mem_addr_o", 64'(mem_addr_o), 64'(xa));
            if (mem_op_o !== op)
               report_mismatch("mem_op_o", 64'(mem_op_o), 64'(op));
            if (op == e_dma_write && mem_wdata_o !== wdata)
               report_mismatch("mem_wdata_o", mem_wdata_o, wdata);
            if (op == e_dma_read)
               expect_read(ch, xa);
         end
         step();
         n++;
      end
      ch_req_v[ch] = 1'b0;
      if (!done)
         report_error($sformatf("channel %0d request was never accepted", ch));
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_q0.size() > 0 || exp_q1.size() > 0 || pend_data.size() > 0)
             && n < DRAIN_TIMEOUT)
      begin
         step();
         n++;
      end
      if (n >= DRAIN_TIMEOUT)
         report_error("read responses did not drain");
   endtask

   ////////////////////////////////////////////////////////////
   // DRAM model and read-return monitor
   ////////////////////////////////////////////////////////////

   // mode flags are taken at the edge, outputs driven 1 ns later
   always @(posedge clk)
   begin
      logic        use_rand;
      logic        use_fixed;
      logic        en;
      logic [31:0] r;
      cyc       = cyc + 1;
      use_rand  = ready_rand;
      use_fixed = ready_fixed;
      en        = resp_en;
      #1;
      if (use_rand)
      begin
         rand_bits(1, r);
         mem_ready = r[0];
      end
      else
         mem_ready = use_fixed;
      if (en && pend_data.size() > 0 && cyc >= pend_due[0])
      begin
         mem_rvalid = 1'b1;
         mem_rdata  = pend_data.pop_front();
         void'(pend_due.pop_front());
      end
      else
      begin
         mem_rvalid = 1'b0;
         mem_rdata  = '0;
      end
   end

   // latency of 1 to 4 cycles per read
   always @(negedge clk)
   begin
      logic [31:0] d;
      if (mem_v_o && mem_ready && mem_op_o == e_dma_read)
      begin
         rand_bits(2, d);
         pend_data.push_back({mem_addr_o, mem_addr_o});
         pend_due.push_back(cyc + int'(d[1:0]) + 1);
      end
   end

   task automatic check_return(input int ch);
      logic [63:0] e;
      if ((ch == 0 && exp_q0.size() == 0) || (ch == 1 && exp_q1.size() == 0))
         report_error($sformatf("read data on channel %0d with no read pending", ch));
      else
      begin
         if (ch == 0)
            e = exp_q0.pop_front();
         else
            e = exp_q1.pop_front();
         if (ch_rdata_o[ch] !== e)
            report_mismatch($sformatf("ch_rdata_o[%0d]", ch), ch_rdata_o[ch], e);
      end
   endtask

   always @(negedge clk)
   begin
      for (int c = 0; c < `DB_NUM_CH; c++)
      begin
         if (ch_rvalid_o[c])
            check_return(c);
      end
   end

   ////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////

   task automatic test_csr_access();
      logic [31:0] d;
      @(negedge clk);
      if (mem_v_o !== 1'b0 || ch_req_yumi_o !== '0 || ch_rvalid_o !== '0)
         report_error("DRAM or channel strobes not low after reset");
      step();
      csr_read(e_csr_ctrl, d);
      if (d !== 32'h0)
         report_mismatch("csr ctrl", 64'(d), 64'h0);
      @(negedge clk);
      if (csr_rvalid_o !== 1'b0)
         report_error("csr_rvalid_o stayed high for more than one cycle");
      step();
      csr_read(e_csr_base, d);
      if (d !== 32'h0)
         report_mismatch("csr base", 64'(d), 64'h0);
      set_base(32'h1234_5000);
      csr_read(e_csr_base, d);
      if (d !== 32'h1234_5000)
         report_mismatch("csr base", 64'(d), 64'h1234_5000);
      // read-only index
      csr_write(e_csr_issued, 32'hdead_beef);
      csr_read(e_csr_issued, d);
      if (d !== 32'h0)
         report_mismatch("csr issued", 64'(d), 64'h0);
      // writable registers keep their values
      csr_read(e_csr_base, d);
      if (d !== 32'h1234_5000)
         report_mismatch("csr base", 64'(d), 64'h1234_5000);
      csr_read(e_csr_ctrl, d);
      if (d !== 32'h0)
         report_mismatch("csr ctrl", 64'(d), 64'h0);
   endtask

   task automatic hold_idle(input int n);
      repeat (n)
      begin
         @(negedge clk);
         if (ch_req_yumi_o !== '0)
            report_mismatch("ch_req_yumi_o", 64'(ch_req_yumi_o), 64'h0);
         if (mem_v_o !== 1'b0)
            report_mismatch("mem_v_o", 64'(mem_v_o), 64'h0);
         step();
      end
   endtask

   task automatic test_gating();
      ready_fixed     = 1'b1;
      ch_req_v[0]     = 1'b1;
      ch_req_op[0]    = e_dma_read;
      ch_req_addr[0]  = 32'h8000_0100;
      csr_write(e_csr_ctrl, 32'h1);
      hold_idle(20);
      csr_write(e_csr_ctrl, 32'h2);
      hold_idle(20);
      ch_req_v[0] = 1'b0;
   endtask

   task automatic test_translation();
      csr_write(e_csr_ctrl, 32'h3);
      set_base(32'h1000_0000);
      resp_en = 1'b1;
      issue(0, e_dma_write, 32'h8000_1000, 64'h0123_4567_89ab_cdef);
      issue(1, e_dma_write, 32'h8123_4560, 64'hfedc_ba98_7654_3210);
      issue(0, e_dma_read, 32'h8765_4320, 64'h0);
      issue(1, e_dma_read, 32'h9000_0008, 64'h0);
      // below the window the top bit flips the other way
      issue(0, e_dma_read, 32'h0000_0010, 64'h0);
      wait_drain();
   endtask

   task automatic test_alternation();
      int prev;
      int cur;
      prev            = -1;
      ch_req_op[0]    = e_dma_write;
      ch_req_op[1]    = e_dma_write;
      ch_req_addr[0]  = 32'h8000_2000;
      ch_req_addr[1]  = 32'h8100_3000;
      ch_req_v        = 2'b11;
      repeat (10)
      begin
         @(negedge clk);
         if (ch_req_yumi_o !== 2'b01 && ch_req_yumi_o !== 2'b10)
            report_mismatch("ch_req_yumi_o one-hot", 64'(ch_req_yumi_o), 64'h1);
         else
         begin
            cur = ch_req_yumi_o[1] ? 1 : 0;
            if (prev >= 0 && cur == prev)
               report_mismatch("winning channel", 64'(cur), 64'(1 - prev));
            prev = cur;
         end
         step();
      end
      ch_req_v = 2'b00;
   endtask

   task automatic channel_reads(input int ch, input int n);
      logic [31:0] a;
      for (int k = 0; k < n; k++)
      begin
         a = 32'h8000_0000 + (32'(ch) << 27) + (32'(k) << 12);
         issue(ch, e_dma_read, a, 64'h0);
      end
   endtask

   task automatic test_random_reads();
      ready_rand = 1'b1;
      resp_en    = 1'b1;
      fork
         channel_reads(0, 12);
         channel_reads(1, 12);
      join
      wait_drain();
      ready_rand = 1'b0;
   endtask

   task automatic test_read_stall();
      int          accepted;
      logic [31:0] d;
      accepted       = 0;
      ready_fixed    = 1'b1;
      resp_en        = 1'b0;
      ch_req_op[0]   = e_dma_read;
      ch_req_addr[0] = 32'h8400_0000;
      ch_req_v[0]    = 1'b1;
      repeat (20)
      begin
         @(negedge clk);
         if (ch_req_yumi_o[0])
         begin
            expect_read(0, xlate(ch_req_addr[0]));
            accepted++;
         end
         step();
         ch_req_addr[0] = 32'h8400_0000 + (32'(accepted) << 6);
      end
      if (accepted != `DB_RQ_DEPTH)
         report_mismatch("accepted reads", 64'(accepted), 64'(`DB_RQ_DEPTH));
      @(negedge clk);
      if (mem_v_o !== 1'b0)
         report_mismatch("mem_v_o", 64'(mem_v_o), 64'h0);
      step();
      csr_read(e_csr_outstanding, d);
      if (d !== 32'd8)
         report_mismatch("csr outstanding", 64'(d), 64'd8);
      issue(1, e_dma_write, 32'h8800_0040, 64'h5555_aaaa_5555_aaaa);
      ch_req_v[0] = 1'b0;
      resp_en     = 1'b1;
      wait_drain();
   endtask

   task automatic test_profiler();
      logic [127:0] prof_exp;
      logic [31:0]  addrs [5];
      logic [31:0]  d;
      csr_write(e_csr_ctrl, 32'h0);
      csr_write(e_csr_ctrl, 32'h3);
      addrs    = '{32'h8000_0000, 32'h8080_0040, 32'h9f80_0100, 32'hbf80_0000, 32'h8080_0800};
      prof_exp = '0;
      for (int i = 0; i < 5; i++)
      begin
         issue(i % 2, (i % 2 != 0) ? e_dma_write : e_dma_read, addrs[i], 64'(i));
         prof_exp[addrs[i][29:23]] = 1'b1;
      end
      wait_drain();
      csr_read(e_csr_issued, d);
      if (d !== 32'd5)
         report_mismatch("csr issued", 64'(d), 64'd5);
      for (int w = 0; w < 4; w++)
      begin
         csr_read(csr_idx_e'(3'(4 + w)), d);
         if (d !== prof_exp[w*32 +: 32])
            report_mismatch($sformatf("profiler word %0d", w), 64'(d),
                            64'(prof_exp[w*32 +: 32]));
      end
      // soft reset clears the statistics
      csr_write(e_csr_ctrl, 32'h0);
      csr_write(e_csr_ctrl, 32'h3);
      csr_read(e_csr_issued, d);
      if (d !== 32'h0)
         report_mismatch("csr issued", 64'(d), 64'h0);
      for (int w = 0; w < 4; w++)
      begin
         csr_read(csr_idx_e'(3'(4 + w)), d);
         if (d !== 32'h0)
            report_mismatch($sformatf("profiler word %0d", w), 64'(d), 64'h0);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // sequence, watchdog and summary
   ////////////////////////////////////////////////////////////

   initial
   begin
      csr_we       = 1'b0;
      csr_re       = 1'b0;
      csr_addr     = e_csr_ctrl;
      csr_wdata    = '0;
      ch_req_v     = '0;
      ch_req_op[0] = e_dma_read;
      ch_req_op[1] = e_dma_read;
      ch_req_addr  = '0;
      ch_req_wdata = '0;
      mem_ready    = 1'b0;
      mem_rvalid   = 1'b0;
      mem_rdata    = '0;
      @(posedge arst_n);
      step();
      test_csr_access();
      test_gating();
      test_translation();
      test_alternation();
      test_random_reads();
      test_read_stall();
      test_profiler();
      step();
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("errors: %0d", errors + 1);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// free-running clock and a reset held low for a few cycles
module tb_clk_gen
  #(parameter int PERIOD_NS    = 4
    , parameter int RESET_CYCLES = 2)
  (output logic clk_o
   , output logic arst_n_o
   );

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS/2) clk_o = ~clk_o;
   end

   // release lands just after a rising edge
   initial
   begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

/* hw/zynq_dram_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_bridge_defs.svh"

module zynq_dram_bridge
  (input wire                                                  clk_i
   , input wire                                                arst_n_i

   // host register bus
   , input wire                                                csr_we_i
   , input wire                                                csr_re_i
   , input wire dram_bridge_pkg::csr_idx_e                     csr_addr_i
   , input wire [`DB_CSR_W-1:0]                                csr_wdata_i
   , output logic [`DB_CSR_W-1:0]                              csr_rdata_o
   , output logic                                              csr_rvalid_o

   // peer DMA channels
   , input wire [`DB_NUM_CH-1:0]                               ch_req_v_i
   , input wire dram_bridge_pkg::dma_op_e [`DB_NUM_CH-1:0]     ch_req_op_i
   , input wire [`DB_NUM_CH-1:0][`DB_ADDR_W-1:0]               ch_req_addr_i
   , input wire [`DB_NUM_CH-1:0][`DB_DATA_W-1:0]               ch_req_wdata_i
   , output logic [`DB_NUM_CH-1:0]                             ch_req_yumi_o
   , output logic [`DB_NUM_CH-1:0]                             ch_rvalid_o
   , output logic [`DB_NUM_CH-1:0][`DB_DATA_W-1:0]             ch_rdata_o

   // host DRAM port
   , output logic                                              mem_v_o
   , input wire                                                mem_ready_i
   , output dram_bridge_pkg::dma_op_e                          mem_op_o
   , output logic [`DB_ADDR_W-1:0]                             mem_addr_o
   , output logic [`DB_DATA_W-1:0]                             mem_wdata_o
   , input wire                                                mem_rvalid_i
   , input wire [`DB_DATA_W-1:0]                               mem_rdata_i
   );

   import dram_bridge_pkg::*;

   logic                               run;
   logic                               dram_init;
   logic [`DB_ADDR_W-1:0]              dram_base;
   logic [`DB_CSR_W-1:0]               issued;
   logic [`DB_PROF_BITS-1:0]           prof;
   logic [$clog2(`DB_RQ_DEPTH+1)-1:0]  rq_count;
   logic                               rq_full;
   logic                               grant_v;
   logic [$clog2(`DB_NUM_CH)-1:0]      grant_ch;
   dma_op_e                            grant_op;
   logic [`DB_ADDR_W-1:0]              grant_addr;
   logic [`DB_DATA_W-1:0]              grant_wdata;

   host_csr_bank csr
     (.clk_i(clk_i), .arst_n_i(arst_n_i)
      ,.csr_we_i(csr_we_i), .csr_re_i(csr_re_i)
      ,.csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i)
      ,.csr_rdata_o(csr_rdata_o), .csr_rvalid_o(csr_rvalid_o)
      ,.run_o(run), .dram_init_o(dram_init), .dram_base_o(dram_base)
      ,.issued_i(issued), .prof_i(prof), .rq_count_i(rq_count)
      );

   dma_rr_arbiter arb
     (.clk_i(clk_i), .arst_n_i(arst_n_i)
      ,.run_i(run), .dram_init_i(dram_init), .rq_full_i(rq_full)
      ,.ch_req_v_i(ch_req_v_i), .ch_req_op_i(ch_req_op_i)
      ,.ch_req_addr_i(ch_req_addr_i), .ch_req_wdata_i(ch_req_wdata_i)
      ,.ch_req_yumi_o(ch_req_yumi_o)
      ,.mem_ready_i(mem_ready_i), .mem_v_o(mem_v_o)
      ,.grant_v_o(grant_v), .grant_ch_o(grant_ch), .grant_op_o(grant_op)
      ,.grant_addr_o(grant_addr), .grant_wdata_o(grant_wdata)
      );

   dram_window win
     (.clk_i(clk_i), .arst_n_i(arst_n_i)
      ,.run_i(run), .dram_base_i(dram_base)
      ,.grant_v_i(grant_v), .grant_addr_i(grant_addr)
      ,.mem_addr_o(mem_addr_o), .issued_o(issued), .prof_o(prof)
      );

   read_return_router rtr
     (.clk_i(clk_i), .arst_n_i(arst_n_i)
      ,.run_i(run), .grant_v_i(grant_v), .grant_ch_i(grant_ch), .grant_op_i(grant_op)
      ,.mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i)
      ,.ch_rvalid_o(ch_rvalid_o), .ch_rdata_o(ch_rdata_o)
      ,.rq_full_o(rq_full), .rq_count_o(rq_count)
      );

   // opcode and write data pass straight from the winning channel
   assign mem_op_o    = grant_op;
   assign mem_wdata_o = grant_wdata;

endmodule

`default_nettype wire

/* hw/read_return_router.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_bridge_defs.svh"

module read_return_router
  (input wire                                        clk_i
   , input wire                                      arst_n_i

   , input wire                                      run_i
   , input wire                                      grant_v_i
   , input wire [$clog2(`DB_NUM_CH)-1:0]             grant_ch_i
   , input wire dram_bridge_pkg::dma_op_e            grant_op_i

   // in-order read data from DRAM
   , input wire                                      mem_rvalid_i
   , input wire [`DB_DATA_W-1:0]                     mem_rdata_i

   , output logic [`DB_NUM_CH-1:0]                   ch_rvalid_o
   , output logic [`DB_NUM_CH-1:0][`DB_DATA_W-1:0]   ch_rdata_o
   , output logic                                    rq_full_o
   , output logic [$clog2(`DB_RQ_DEPTH+1)-1:0]       rq_count_o
   );

   import dram_bridge_pkg::*;

   localparam int CH_W  = $clog2(`DB_NUM_CH);
   localparam int PTR_W = $clog2(`DB_RQ_DEPTH);
   localparam int CNT_W = $clog2(`DB_RQ_DEPTH+1);

   logic [CH_W-1:0]  tag_q [`DB_RQ_DEPTH];
   logic [PTR_W-1:0] wr_ptr_r;
   logic [PTR_W-1:0] rd_ptr_r;
   logic [CNT_W-1:0] count_r;
   logic             push;
   logic             pop;

   // only reads expect a response
   assign push = grant_v_i & (grant_op_i == e_dma_read);
   assign pop  = mem_rvalid_i & (count_r != '0);

   always_ff @(posedge clk_i)
   begin
      if (push)
         tag_q[wr_ptr_r] <= grant_ch_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else if (!run_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (pop)
            rd_ptr_r <= rd_ptr_r + 1'b1;
         if (push && !pop)
            count_r <= count_r + 1'b1;
         else if (pop && !push)
            count_r <= count_r - 1'b1;
      end
   end

   // steer the valid to the oldest tag, data goes everywhere
   always_comb
   begin
      for (int i = 0; i < `DB_NUM_CH; i++)
      begin
         ch_rvalid_o[i] = pop & (tag_q[rd_ptr_r] == CH_W'(i));
         ch_rdata_o[i]  = mem_rdata_i;
      end
   end

   assign rq_full_o  = (count_r == CNT_W'(`DB_RQ_DEPTH));
   assign rq_count_o = count_r;

endmodule

`default_nettype wire

/* hw/dram_window.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_bridge_defs.svh"

module dram_window
  (input wire                          clk_i
   , input wire                        arst_n_i

   , input wire                        run_i
   , input wire [`DB_ADDR_W-1:0]       dram_base_i

   // accepted request from the arbiter
   , input wire                        grant_v_i
   , input wire [`DB_ADDR_W-1:0]       grant_addr_i

   , output logic [`DB_ADDR_W-1:0]     mem_addr_o
   , output logic [`DB_CSR_W-1:0]      issued_o
   , output logic [`DB_PROF_BITS-1:0]  prof_o
   );

   localparam int REG_W = $clog2(`DB_PROF_BITS);

   logic [REG_W-1:0]         region;
   logic [`DB_PROF_BITS-1:0] prof_r;
   logic [`DB_CSR_W-1:0]     issued_r;

   ////////////////////////////////////////////////////////////
   // address translation
   ////////////////////////////////////////////////////////////

   // strip the processor window base, then rebase into host DRAM
   assign mem_addr_o = (grant_addr_i ^ `DB_WINDOW_BASE) + dram_base_i;

   ////////////////////////////////////////////////////////////
   // usage statistics
   ////////////////////////////////////////////////////////////

   // region taken from the untranslated address
   assign region = grant_addr_i[`DB_PROF_MSB -: REG_W];

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         prof_r <= '0;
      else if (!run_i)
         prof_r <= '0;
      else if (grant_v_i)
         prof_r[region] <= 1'b1;
   end

   // wraps at 2^32
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         issued_r <= '0;
      else if (!run_i)
         issued_r <= '0;
      else if (grant_v_i)
         issued_r <= issued_r + 1'b1;
   end

   assign issued_o = issued_r;
   assign prof_o   = prof_r;

endmodule

`default_nettype wire

/* hw/dma_rr_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_bridge_defs.svh"

module dma_rr_arbiter
  (input wire                                                  clk_i
   , input wire                                                arst_n_i

   , input wire                                                run_i
   , input wire                                                dram_init_i
   , input wire                                                rq_full_i

   // peer channel requests
   , input wire [`DB_NUM_CH-1:0]                               ch_req_v_i
   , input wire dram_bridge_pkg::dma_op_e [`DB_NUM_CH-1:0]     ch_req_op_i
   , input wire [`DB_NUM_CH-1:0][`DB_ADDR_W-1:0]               ch_req_addr_i
   , input wire [`DB_NUM_CH-1:0][`DB_DATA_W-1:0]               ch_req_wdata_i
   , output logic [`DB_NUM_CH-1:0]                             ch_req_yumi_o

   // DRAM side handshake and winning request
   , input wire                                                mem_ready_i
   , output logic                                              mem_v_o
   , output logic                                              grant_v_o
   , output logic [$clog2(`DB_NUM_CH)-1:0]                     grant_ch_o
   , output dram_bridge_pkg::dma_op_e                          grant_op_o
   , output logic [`DB_ADDR_W-1:0]                             grant_addr_o
   , output logic [`DB_DATA_W-1:0]                             grant_wdata_o
   );

   import dram_bridge_pkg::*;

   localparam int CH_W = $clog2(`DB_NUM_CH);

   logic [`DB_NUM_CH-1:0] elig;
   logic                  pick_v;
   logic [CH_W-1:0]       pick;
   logic [CH_W-1:0]       last_r;

   // reads also need room in the return queue
   always_comb
   begin
      for (int i = 0; i < `DB_NUM_CH; i++)
      begin
         elig[i] = ch_req_v_i[i] & run_i & dram_init_i
                   & ((ch_req_op_i[i] == e_dma_write) | ~rq_full_i);
      end
   end

   // search starts one past the last winner
   always_comb
   begin
      int unsigned idx;
      pick_v = 1'b0;
      pick   = last_r;
      for (int k = 1; k <= `DB_NUM_CH; k++)
      begin
         idx = (int'(last_r) + k) % `DB_NUM_CH;
         if (!pick_v && elig[idx])
         begin
            pick_v = 1'b1;
            pick   = CH_W'(idx);
         end
      end
   end

   assign mem_v_o       = pick_v;
   assign grant_v_o     = pick_v & mem_ready_i;
   assign grant_ch_o    = pick;
   assign grant_op_o    = ch_req_op_i[pick];
   assign grant_addr_o  = ch_req_addr_i[pick];
   assign grant_wdata_o = ch_req_wdata_i[pick];

   always_comb
   begin
      ch_req_yumi_o = '0;
      if (grant_v_o)
         ch_req_yumi_o[pick] = 1'b1;
   end

   // pointer holds under back-pressure
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         last_r <= CH_W'(`DB_NUM_CH-1);
      else if (grant_v_o)
         last_r <= pick;
   end

endmodule

`default_nettype wire

/* hw/host_csr_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_bridge_defs.svh"

module host_csr_bank
  (input wire                                 clk_i
   , input wire                               arst_n_i

   // host register strobes
   , input wire                               csr_we_i
   , input wire                               csr_re_i
   , input wire dram_bridge_pkg::csr_idx_e    csr_addr_i
   , input wire [`DB_CSR_W-1:0]               csr_wdata_i
   , output logic [`DB_CSR_W-1:0]             csr_rdata_o
   , output logic                             csr_rvalid_o

   // control out to the datapath
   , output logic                             run_o
   , output logic                             dram_init_o
   , output logic [`DB_ADDR_W-1:0]            dram_base_o

   // status back from the datapath
   , input wire [`DB_CSR_W-1:0]               issued_i
   , input wire [`DB_PROF_BITS-1:0]           prof_i
   , input wire [$clog2(`DB_RQ_DEPTH+1)-1:0]  rq_count_i
   );

   import dram_bridge_pkg::*;

   logic                  run_r;
   logic                  dram_init_r;
   logic [`DB_ADDR_W-1:0] base_r;
   logic [`DB_CSR_W-1:0]  rdata_mux;
   logic [`DB_CSR_W-1:0]  rdata_r;
   logic                  rvalid_r;

   ////////////////////////////////////////////////////////////
   // writable registers
   ////////////////////////////////////////////////////////////

   // only ctrl and base are writable
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         run_r       <= 1'b0;
         dram_init_r <= 1'b0;
         base_r      <= '0;
      end
      else if (csr_we_i)
      begin
         case (csr_addr_i)
            e_csr_ctrl:
            begin
               run_r       <= csr_wdata_i[0];
               dram_init_r <= csr_wdata_i[1];
            end
            e_csr_base:
               base_r <= csr_wdata_i;
            default:
               ;
         endcase
      end
   end

   assign run_o       = run_r;
   assign dram_init_o = dram_init_r;
   assign dram_base_o = base_r;

   ////////////////////////////////////////////////////////////
   // read-back
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      rdata_mux = '0;
      case (csr_addr_i)
         e_csr_ctrl:        rdata_mux[1:0] = {dram_init_r, run_r};
         e_csr_base:        rdata_mux = base_r;
         e_csr_outstanding: rdata_mux[$bits(rq_count_i)-1:0] = rq_count_i;
         e_csr_issued:      rdata_mux = issued_i;
         e_csr_prof0:       rdata_mux = prof_i[0*`DB_CSR_W +: `DB_CSR_W];
         e_csr_prof1:       rdata_mux = prof_i[1*`DB_CSR_W +: `DB_CSR_W];
         e_csr_prof2:       rdata_mux = prof_i[2*`DB_CSR_W +: `DB_CSR_W];
         e_csr_prof3:       rdata_mux = prof_i[3*`DB_CSR_W +: `DB_CSR_W];
         default:           rdata_mux = '0;
      endcase
   end

   // data shows up the cycle after the read strobe
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         rvalid_r <= 1'b0;
      else
         rvalid_r <= csr_re_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (csr_re_i)
         rdata_r <= rdata_mux;
   end

   assign csr_rdata_o  = rdata_r;
   assign csr_rvalid_o = rvalid_r;

endmodule

`default_nettype wire

/* hw/dram_bridge_pkg.sv */
`default_nettype none

`include "dram_bridge_defs.svh"

package dram_bridge_pkg;

   // request opcode shared by the channels and the DRAM port
   typedef enum logic
   {
      e_dma_read  = 1'b0,
      e_dma_write = 1'b1
   } dma_op_e;

   // host register word index
   typedef enum logic [`DB_CSR_AW-1:0]
   {
      e_csr_ctrl        = 0,
      e_csr_base        = 1,
      e_csr_outstanding = 2,
      e_csr_issued      = 3,
      e_csr_prof0       = 4,
      e_csr_prof1       = 5,
      e_csr_prof2       = 6,
      e_csr_prof3       = 7
   } csr_idx_e;

endpackage

`default_nettype wire

/* include/dram_bridge_defs.svh */
`ifndef DRAM_BRIDGE_DEFS_SVH
`define DRAM_BRIDGE_DEFS_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////
`define DB_NUM_CH      2
`define DB_ADDR_W      32
`define DB_DATA_W      64
`define DB_CSR_W       32
`define DB_CSR_AW      3

// processor view of DRAM starts here
`define DB_WINDOW_BASE 32'h8000_0000

// profiler covers 128 regions of 8 MiB, addr[29:23]
`define DB_PROF_MSB    29
`define DB_PROF_BITS   128

// reads that may be in flight at once
`define DB_RQ_DEPTH    8

`endif
